/* source/dma_pkg.sv */
package dma_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int ADDR_W  = 64;   // host address
  localparam int LEN_W   = 32;   // bytes per command
  localparam int COUNT_W = 32;   // event counters
  localparam int TOTAL_W = 48;   // running length total
  localparam int DATA_W  = 512;  // one stream word
  localparam int CHAN_W  = 1;    // enough for rd + wr

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [LEN_W-1:0]   len_t;
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [TOTAL_W-1:0] total_len_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [CHAN_W-1:0]  chan_t;

  // channel numbering
  localparam chan_t CHAN_RD = 1'b0;  // host to card
  localparam chan_t CHAN_WR = 1'b1;  // card to host

  //////////////////////////////////////////////////
  // bundles

  // command from the user side, 97 bits
  typedef struct packed {
    chan_t chan;
    len_t  len;
    addr_t addr;
  } dma_cmd_t;

  // descriptor bypass toward the engine, 97 bits
  typedef struct packed {
    logic  load;  // one-cycle strobe
    addr_t addr;
    len_t  len;
  } dsc_byp_t;

  // one stream beat, 514 bits
  typedef struct packed {
    logic  valid;
    logic  last;  // closes a packet
    data_t data;
  } data_beat_t;

  // statistics register select
  typedef enum logic [2:0] {
    STAT_CMD    = 3'd0,
    STAT_LOAD   = 3'd1,
    STAT_WORD   = 3'd2,
    STAT_PKG    = 3'd3,
    STAT_LEN_LO = 3'd4,  // total[31:0]
    STAT_LEN_HI = 3'd5   // total[47:32], zero extended
  } stat_sel_e;

endpackage

/* source/dma_cmd_dispatch.sv */
`timescale 1ns/1ns

// single command port fanned out to the channels
module dma_cmd_dispatch #(
  parameter int N_CHANNELS = 2
) (
  input  logic                    pcie_clk,
  input  dma_pkg::dma_cmd_t       cmd,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  logic [N_CHANNELS-1:0]   chan_byp_ready,
  output dma_pkg::dma_cmd_t       chan_cmd,
  output logic [N_CHANNELS-1:0]   chan_cmd_valid
);

  //////////////////////////////////////////////////
  // payload

  // every channel sees the same command word
  // and only the valid picks who takes it
  assign chan_cmd = cmd;

  //////////////////////////////////////////////////
  // valid decode and ready select

  // decode only
  // the target channel accepts in the cycle it sees valid and ready
  always_comb begin
    chan_cmd_valid = '0;
    cmd_ready      = 1'b0;  // out of range chan never ready
    for (int i = 0; i < N_CHANNELS; i++) begin
      if (int'(cmd.chan) == i) begin
        chan_cmd_valid[i] = cmd_valid;         // one-hot
        cmd_ready         = chan_byp_ready[i]; // ready of target only
      end
    end
  end

  // cmd_ready has no cmd_valid term
  // since the channel tests valid and ready itself

endmodule

/* source/dma_channel.sv */
`timescale 1ns/1ns

// one dma channel: descriptor bypass, data pass-through, stats
module dma_channel (
  input  logic                 pcie_clk,
  input  logic                 pcie_aresetn,
  // command side
  input  dma_pkg::dma_cmd_t    cmd,
  input  logic                 cmd_valid,
  input  logic                 byp_ready,
  output dma_pkg::dsc_byp_t    byp,
  // stream
  input  dma_pkg::data_beat_t  data_in,
  output logic                 data_in_ready,
  output dma_pkg::data_beat_t  data_out,
  input  logic                 data_out_ready,
  // statistics
  input  logic                 len_clr,
  output dma_pkg::count_t      cmd_count,
  output dma_pkg::count_t      load_count,
  output dma_pkg::count_t      word_count,
  output dma_pkg::count_t      pkg_count,
  output dma_pkg::total_len_t  len_total,
  output logic                 flushed
);

  logic             cmd_accept;  // cmd handshake this cycle
  logic             word_fire;   // beat handshake this cycle
  logic             load_q;
  dma_pkg::addr_t   addr_q;
  dma_pkg::len_t    len_q;

  //////////////////////////////////////////////////
  // descriptor bypass

  assign cmd_accept = cmd_valid & byp_ready;  // ready comes straight from the engine

  // load strobe, exactly one cycle per accepted cmd
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      load_q <= 1'b0;
    end else begin
      load_q <= cmd_accept;
    end
  end

  // addr/len hold their last value between loads
  always_ff @(posedge pcie_clk) begin
    if (cmd_accept) begin
      addr_q <= cmd.addr;
      len_q  <= cmd.len;
    end
  end

  assign byp.load = load_q;
  assign byp.addr = addr_q;
  assign byp.len  = len_q;

  //////////////////////////////////////////////////
  // data stream

  assign data_out      = data_in;          // no buffering
  assign data_in_ready = data_out_ready;   // backpressure passes straight up
  assign word_fire     = data_in.valid & data_out_ready;

  //////////////////////////////////////////////////
  // statistics

  // all counters wrap
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      cmd_count  <= '0;
      load_count <= '0;
      word_count <= '0;
      pkg_count  <= '0;
    end else begin
      if (cmd_accept) begin
        cmd_count <= cmd_count + 1'b1;
      end
      if (load_q) begin
        load_count <= load_count + 1'b1;  // counts the strobe, not the accept
      end
      if (word_fire) begin
        word_count <= word_count + 1'b1;
        if (data_in.last) begin
          pkg_count <= pkg_count + 1'b1;  // end of packet
        end
      end
    end
  end

  // running byte total, clear beats a same-cycle add
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      len_total <= '0;
    end else if (len_clr) begin
      len_total <= '0;
    end else if (cmd_accept) begin
      len_total <= len_total + dma_pkg::total_len_t'(cmd.len);
    end
  end

  // one cycle behind the counters
  // starts at 1 since both counts are 0 out of reset
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      flushed <= 1'b1;
    end else begin
      flushed <= (cmd_count == pkg_count);
    end
  end

endmodule

/* source/dma_stats_readout.sv */
`timescale 1ns/1ns

// one registered read port over all channel counters
module dma_stats_readout #(
  parameter int N_CHANNELS = 2
) (
  input  logic                                    pcie_clk,
  input  logic                                    pcie_aresetn,
  input  dma_pkg::chan_t                          stat_chan,
  input  dma_pkg::stat_sel_e                      stat_sel,
  input  dma_pkg::count_t     [N_CHANNELS-1:0]    cmd_count,
  input  dma_pkg::count_t     [N_CHANNELS-1:0]    load_count,
  input  dma_pkg::count_t     [N_CHANNELS-1:0]    word_count,
  input  dma_pkg::count_t     [N_CHANNELS-1:0]    pkg_count,
  input  dma_pkg::total_len_t [N_CHANNELS-1:0]    len_total,
  output dma_pkg::count_t                         stat_rdata
);

  dma_pkg::total_len_t total_sel;  // length total of the picked channel
  dma_pkg::count_t     rdata_d;

  //////////////////////////////////////////////////
  // select

  always_comb begin
    total_sel = '0;
    rdata_d   = '0;  // bad channel or bad sel reads 0
    if (int'(stat_chan) < N_CHANNELS) begin
      total_sel = len_total[stat_chan];
      case (stat_sel)
        dma_pkg::STAT_CMD:    rdata_d = cmd_count[stat_chan];
        dma_pkg::STAT_LOAD:   rdata_d = load_count[stat_chan];
        dma_pkg::STAT_WORD:   rdata_d = word_count[stat_chan];
        dma_pkg::STAT_PKG:    rdata_d = pkg_count[stat_chan];
        dma_pkg::STAT_LEN_LO: rdata_d = total_sel[31:0];
        dma_pkg::STAT_LEN_HI: rdata_d = dma_pkg::count_t'(total_sel[47:32]);  // upper 16 zero
        default:              rdata_d = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // output register

  // data valid one cycle after chan/sel are presented
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      stat_rdata <= '0;
    end else begin
      stat_rdata <= rdata_d;
    end
  end

endmodule

/* source/dma_bypass_top.sv */
`timescale 1ns/1ns

// dma bypass shim, dispatcher + channels + stats port
module dma_bypass_top #(
  parameter int N_CHANNELS = 2
) (
  input  logic                                    pcie_clk,
  input  logic                                    pcie_aresetn,
  // command intake
  input  dma_pkg::dma_cmd_t                       cmd,
  input  logic                                    cmd_valid,
  output logic                                    cmd_ready,
  // descriptor bypass, index 0 = h2c, 1 = c2h
  input  logic                [N_CHANNELS-1:0]    byp_ready,
  output dma_pkg::dsc_byp_t   [N_CHANNELS-1:0]    byp,
  // streams
  input  dma_pkg::data_beat_t [N_CHANNELS-1:0]    data_in,
  output logic                [N_CHANNELS-1:0]    data_in_ready,
  output dma_pkg::data_beat_t [N_CHANNELS-1:0]    data_out,
  input  logic                [N_CHANNELS-1:0]    data_out_ready,
  // stats control
  input  logic                [N_CHANNELS-1:0]    len_clr,
  output logic                [N_CHANNELS-1:0]    flushed,
  input  dma_pkg::chan_t                          stat_chan,
  input  dma_pkg::stat_sel_e                      stat_sel,
  output dma_pkg::count_t                         stat_rdata
);

  dma_pkg::dma_cmd_t                      chan_cmd;        // shared by all channels
  logic                [N_CHANNELS-1:0]   chan_cmd_valid;  // one-hot
  dma_pkg::count_t     [N_CHANNELS-1:0]   cmd_count;
  dma_pkg::count_t     [N_CHANNELS-1:0]   load_count;
  dma_pkg::count_t     [N_CHANNELS-1:0]   word_count;
  dma_pkg::count_t     [N_CHANNELS-1:0]   pkg_count;
  dma_pkg::total_len_t [N_CHANNELS-1:0]   len_total;

  //////////////////////////////////////////////////
  // command routing

  dma_cmd_dispatch #(
    .N_CHANNELS (N_CHANNELS)
  ) dma_cmd_dispatch_inst (
    .pcie_clk       (pcie_clk),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .chan_byp_ready (byp_ready),     // engine ready doubles as cmd ready
    .chan_cmd       (chan_cmd),
    .chan_cmd_valid (chan_cmd_valid)
  );

  //////////////////////////////////////////////////
  // channels

  for (genvar i = 0; i < N_CHANNELS; i++) begin : g_chan
    dma_channel dma_channel_inst (
      .pcie_clk       (pcie_clk),
      .pcie_aresetn   (pcie_aresetn),
      .cmd            (chan_cmd),
      .cmd_valid      (chan_cmd_valid[i]),
      .byp_ready      (byp_ready[i]),
      .byp            (byp[i]),
      .data_in        (data_in[i]),
      .data_in_ready  (data_in_ready[i]),
      .data_out       (data_out[i]),
      .data_out_ready (data_out_ready[i]),
      .len_clr        (len_clr[i]),
      .cmd_count      (cmd_count[i]),
      .load_count     (load_count[i]),
      .word_count     (word_count[i]),
      .pkg_count      (pkg_count[i]),
      .len_total      (len_total[i]),
      .flushed        (flushed[i])
    );
  end

  //////////////////////////////////////////////////
  // stats read port

  dma_stats_readout #(
    .N_CHANNELS (N_CHANNELS)
  ) dma_stats_readout_inst (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .stat_chan    (stat_chan),
    .stat_sel     (stat_sel),
    .cmd_count    (cmd_count),
    .load_count   (load_count),
    .word_count   (word_count),
    .pkg_count    (pkg_count),
    .len_total    (len_total),
    .stat_rdata   (stat_rdata)  // registered, 1 cycle
  );

endmodule

/* dv/dma_bypass_checker.sv */
`timescale 1ns/1ns

// strobe and ready checks, bound into every channel
module dma_bypass_checker (
  input logic pcie_clk,
  input logic pcie_aresetn,
  input logic cmd_valid,
  input logic byp_ready,
  input logic load,
  input logic data_in_ready,
  input logic data_out_ready
);

  logic accept;

  assign accept = cmd_valid & byp_ready;  // same test as the channel

  //////////////////////////////////////////////////
  // descriptor load

  // only a fresh accept may keep load up
  load_one_cycle: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
      load && !accept |=> !load)
    else $error("load strobe stayed high without a new command");

  load_after_accept: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
      accept |=> load)
    else $error("accepted command gave no load one cycle later");

  //////////////////////////////////////////////////
  // stream

  ready_passthrough: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
      data_in_ready == data_out_ready)
    else $error("data_in_ready differs from data_out_ready");

endmodule

bind dma_channel dma_bypass_checker dma_bypass_checker_inst (
  .pcie_clk       (pcie_clk),
  .pcie_aresetn   (pcie_aresetn),
  .cmd_valid      (cmd_valid),
  .byp_ready      (byp_ready),
  .load           (byp.load),
  .data_in_ready  (data_in_ready),
  .data_out_ready (data_out_ready)
);

/* dv/dma_bypass_tb.sv */
`timescale 1ns/1ns

module dma_bypass_tb;

  localparam int N_CHANNELS = 2;
  localparam int N_CYCLES   = 3000;  // random traffic
  localparam int N_IDLE     = 24;    // drain and walk every stat register
  localparam int TIMEOUT_NS = (N_CYCLES + N_IDLE + 10) * 100 + 5000;

  typedef logic [513:0] wide_t;  // widest compared value is one beat

  logic                                   pcie_clk = 1'b0;
  logic                                   pcie_aresetn;
  dma_pkg::dma_cmd_t                      cmd;
  logic                                   cmd_valid;
  logic                                   cmd_ready;
  logic                [N_CHANNELS-1:0]   byp_ready;
  dma_pkg::dsc_byp_t   [N_CHANNELS-1:0]   byp;
  dma_pkg::data_beat_t [N_CHANNELS-1:0]   data_in;
  logic                [N_CHANNELS-1:0]   data_in_ready;
  dma_pkg::data_beat_t [N_CHANNELS-1:0]   data_out;
  logic                [N_CHANNELS-1:0]   data_out_ready;
  logic                [N_CHANNELS-1:0]   len_clr;
  logic                [N_CHANNELS-1:0]   flushed;
  dma_pkg::chan_t                         stat_chan;
  dma_pkg::stat_sel_e                     stat_sel;
  dma_pkg::count_t                        stat_rdata;

  // per channel reference model
  dma_pkg::count_t     m_cmd      [N_CHANNELS];
  dma_pkg::count_t     m_load_cnt [N_CHANNELS];
  dma_pkg::count_t     m_word     [N_CHANNELS];
  dma_pkg::count_t     m_pkg      [N_CHANNELS];
  dma_pkg::total_len_t m_total    [N_CHANNELS];
  logic                m_load     [N_CHANNELS];  // pending strobe
  dma_pkg::addr_t      m_addr     [N_CHANNELS];
  dma_pkg::len_t       m_len      [N_CHANNELS];
  logic                m_byp_set  [N_CHANNELS];  // addr/len defined once loaded
  logic                m_flushed  [N_CHANNELS];
  dma_pkg::count_t     m_rdata;
  logic                cmd_waiting;  // cmd held at the port and not yet taken

  logic [31:0] lfsr   = 32'h984d;
  int          errors = 0;
  int          checks = 0;

  dma_bypass_top #(
    .N_CHANNELS (N_CHANNELS)
  ) dma_bypass_top_inst (.*);

  always #50 pcie_clk = ~pcie_clk;  // 100 ns period

  //////////////////////////////////////////////////
  // random source

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [511:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v    = {v[510:0], lfsr[31]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic compare(input string name, input wide_t exp, input wide_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // model

  task automatic model_reset();
    for (int c = 0; c < N_CHANNELS; c++) begin
      m_cmd[c]      = '0;
      m_load_cnt[c] = '0;
      m_word[c]     = '0;
      m_pkg[c]      = '0;
      m_total[c]    = '0;
      m_load[c]     = 1'b0;
      m_byp_set[c]  = 1'b0;
      m_flushed[c]  = 1'b1;  // 0 == 0 out of reset
    end
    m_rdata     = '0;
    cmd_waiting = 1'b0;
  endtask

  function automatic dma_pkg::count_t stat_model(input int ch, input dma_pkg::stat_sel_e sel);
    case (sel)
      dma_pkg::STAT_CMD:    return m_cmd[ch];
      dma_pkg::STAT_LOAD:   return m_load_cnt[ch];
      dma_pkg::STAT_WORD:   return m_word[ch];
      dma_pkg::STAT_PKG:    return m_pkg[ch];
      dma_pkg::STAT_LEN_LO: return m_total[ch][31:0];
      dma_pkg::STAT_LEN_HI: return {16'h0, m_total[ch][47:32]};
      default:              return '0;  // 6 and 7 read zero
    endcase
  endfunction

  // advance the model across the next rising edge
  task automatic model_step();
    logic acc;
    logic fire;
    m_rdata = stat_model(int'(stat_chan), stat_sel);  // counters before the edge
    for (int c = 0; c < N_CHANNELS; c++) begin
      acc  = cmd_valid && byp_ready[c] && (int'(cmd.chan) == c);
      fire = data_in[c].valid && data_out_ready[c];
      m_flushed[c]  = (m_cmd[c] == m_pkg[c]);  // one edge behind counters
      m_load_cnt[c] = m_load_cnt[c] + dma_pkg::count_t'(m_load[c]);
      m_load[c]     = acc;
      if (acc) begin
        m_addr[c]    = cmd.addr;
        m_len[c]     = cmd.len;
        m_byp_set[c] = 1'b1;
      end
      m_cmd[c]  = m_cmd[c] + dma_pkg::count_t'(acc);
      m_word[c] = m_word[c] + dma_pkg::count_t'(fire);
      m_pkg[c]  = m_pkg[c] + dma_pkg::count_t'(fire && data_in[c].last);
      if (len_clr[c]) begin
        m_total[c] = '0;  // clear wins over the add
      end else if (acc) begin
        m_total[c] = m_total[c] + dma_pkg::total_len_t'(cmd.len);
      end
    end
    cmd_waiting = cmd_valid && !byp_ready[cmd.chan];
  endtask

  //////////////////////////////////////////////////
  // stimulus and checks

  task automatic drive_inputs(input bit traffic, input logic [3:0] rd_idx);
    logic [511:0] r;
    for (int c = 0; c < N_CHANNELS; c++) begin
      take_bits(2, r);
      byp_ready[c] = |r[1:0];       // ready 3 of 4
      take_bits(2, r);
      data_out_ready[c] = |r[1:0];
      take_bits(3, r);
      len_clr[c] = traffic && (r[2:0] == 3'd0);  // rare clear
      take_bits(2, r);
      data_in[c].valid = traffic && r[0];
      data_in[c].last  = r[1];
      take_bits(512, r);
      data_in[c].data = r;
    end
    if (!cmd_waiting) begin  // a waiting cmd stays put
      take_bits(1, r);
      cmd_valid = traffic && r[0];
      take_bits(1, r);
      cmd.chan = r[0];
      take_bits(32, r);
      cmd.len = r[31:0];
      take_bits(64, r);
      cmd.addr = r[63:0];
    end
    take_bits(4, r);
    if (!traffic) begin
      r[3:0] = rd_idx;  // walk chan/sel in order
    end
    stat_chan = r[3];
    stat_sel  = dma_pkg::stat_sel_e'(r[2:0]);
  endtask

  // outputs that moved at the last rising edge
  task automatic check_registered();
    for (int c = 0; c < N_CHANNELS; c++) begin
      compare($sformatf("byp[%0d].load", c), wide_t'(m_load[c]), wide_t'(byp[c].load));
      if (m_byp_set[c]) begin  // addr/len also held between loads
        compare($sformatf("byp[%0d].addr", c), wide_t'(m_addr[c]), wide_t'(byp[c].addr));
        compare($sformatf("byp[%0d].len", c), wide_t'(m_len[c]), wide_t'(byp[c].len));
      end
      compare($sformatf("flushed[%0d]", c), wide_t'(m_flushed[c]), wide_t'(flushed[c]));
    end
    compare("stat_rdata", wide_t'(m_rdata), wide_t'(stat_rdata));
  endtask

  // combinational paths settled 1 ns after the drive
  task automatic check_comb();
    compare("cmd_ready", wide_t'(byp_ready[cmd.chan]), wide_t'(cmd_ready));
    for (int c = 0; c < N_CHANNELS; c++) begin
      compare($sformatf("data_in_ready[%0d]", c), wide_t'(data_out_ready[c]),
              wide_t'(data_in_ready[c]));
      compare($sformatf("data_out[%0d]", c), wide_t'(data_in[c]), wide_t'(data_out[c]));
    end
  endtask

  initial begin
    pcie_aresetn   = 1'b0;
    cmd            = '0;
    cmd_valid      = 1'b0;
    byp_ready      = '0;
    data_in        = '0;
    data_out_ready = '0;
    len_clr        = '0;
    stat_chan      = '0;
    stat_sel       = dma_pkg::STAT_CMD;
    model_reset();
    repeat (3) @(posedge pcie_clk);
    @(negedge pcie_clk);
    pcie_aresetn = 1'b1;
    for (int n = 0; n < N_CYCLES + N_IDLE; n++) begin
      check_registered();
      drive_inputs(n < N_CYCLES, 4'(n - N_CYCLES));
      #1;
      check_comb();
      model_step();
      @(negedge pcie_clk);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout, the test did not finish within %0d ns", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

/* all.f */
source/dma_pkg.sv
source/dma_cmd_dispatch.sv
source/dma_channel.sv
source/dma_stats_readout.sv
source/dma_bypass_top.sv
dv/dma_bypass_checker.sv
dv/dma_bypass_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dma_bypass_tb -f all.f -o dma_bypass_sim
./obj_dir/dma_bypass_sim > sim.log 2>&1
cat sim.log

# exit status follows the search
grep -q "Regression passed" sim.log
